//--- rtl/calc_defs.svh
/*
 * Calculator widths and depths
 * Data, register address and operation code widths, completion pipe depth
 */
`ifndef CALC_DEFS_SVH
`define CALC_DEFS_SVH

// One integer data word
`define CALC_DWORD_W 32

// Architectural register address
`define CALC_REG_ADDR_W 5

// Completion stages after the reservation register
`define CALC_STAGES 3

// Operation code
`define CALC_OP_W 4

`endif

//--- rtl/calc_pkg.sv
/*
 * Calculator package
 * Vector types, operation codes and the packets passed between blocks
 */
`include "calc_defs.svh"

package calc_pkg;

  typedef logic [`CALC_DWORD_W-1:0] dword_t;
  typedef logic [`CALC_REG_ADDR_W-1:0] reg_addr_t;

  typedef enum logic [`CALC_OP_W-1:0]
  {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLL,
    OP_SRL,
    OP_SLT,
    OP_MUL,
    OP_MULH,
    OP_MULHU
  } calc_op_e;

  // Register values are read by the issuer before dispatch
  typedef struct packed
  {
    logic      v;
    logic      pipe_int_v;
    logic      pipe_mul_v;
    logic      irf_w_v;
    calc_op_e  op;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    dword_t    rs1;
    dword_t    rs2;
    dword_t    imm;
    logic      use_imm;
  } dispatch_pkt_s;

  typedef struct packed
  {
    logic      v;
    logic      poison;
    logic      pipe_int_v;
    logic      pipe_mul_v;
    logic      irf_w_v;
    reg_addr_t rd_addr;
  } stage_meta_s;

  typedef struct packed
  {
    logic      v;
    reg_addr_t rd_addr;
    dword_t    data;
  } fwd_slot_s;

  typedef struct packed
  {
    logic      rd_w_v;
    reg_addr_t rd_addr;
    dword_t    rd_data;
  } wb_pkt_s;

endpackage

//--- rtl/calc_ctrl.sv
/*
 * Calculator control
 * Shifts per-stage metadata and poison, builds forwarding slots and writeback valid
 */
`include "calc_defs.svh"

module calc_ctrl
(
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  calc_pkg::dispatch_pkt_s              dispatch_pkt_i,
  input  logic                                 flush_i,
  output calc_pkg::fwd_slot_s [`CALC_STAGES:1] fwd_o,
  output logic                                 int_done_o,
  output logic                                 mul_done_o,
  output logic                                 wb_w_v_o,
  output calc_pkg::reg_addr_t                  wb_rd_addr_o
);

  import calc_pkg::*;

  // Stage whose register holds the instruction when its pipe finishes
  localparam int INT_DONE_STAGE = 0;
  localparam int MUL_DONE_STAGE = 1;

  // Index 0 is the reservation register, 1..N the completion stages
  stage_meta_s [`CALC_STAGES:0] meta_r;
  stage_meta_s [`CALC_STAGES:0] meta_n;

  always_comb
  begin
    meta_n[0].v          = dispatch_pkt_i.v;
    meta_n[0].poison     = flush_i;
    meta_n[0].pipe_int_v = dispatch_pkt_i.pipe_int_v;
    meta_n[0].pipe_mul_v = dispatch_pkt_i.pipe_mul_v;
    meta_n[0].irf_w_v    = dispatch_pkt_i.irf_w_v;
    meta_n[0].rd_addr    = dispatch_pkt_i.rd_addr;
    // Flush kills everything still in flight
    for (int k = 1; k <= `CALC_STAGES; k++)
    begin
      meta_n[k]        = meta_r[k-1];
      meta_n[k].poison = meta_r[k-1].poison | flush_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      meta_r <= '0;
    end
    else
    begin
      meta_r <= meta_n;
    end
  end

  // Slot k describes what stage k captures at the coming edge
  always_comb
  begin
    for (int k = 1; k <= `CALC_STAGES; k++)
    begin
      fwd_o[k].v       = meta_n[k].v & meta_n[k].irf_w_v & ~meta_n[k].poison;
      fwd_o[k].rd_addr = meta_n[k].rd_addr;
      fwd_o[k].data    = '0;
    end
  end

  assign int_done_o = meta_r[INT_DONE_STAGE].v & meta_r[INT_DONE_STAGE].pipe_int_v;
  assign mul_done_o = meta_r[MUL_DONE_STAGE].v & meta_r[MUL_DONE_STAGE].pipe_mul_v;

  assign wb_w_v_o = meta_r[`CALC_STAGES].v & meta_r[`CALC_STAGES].irf_w_v
                    & ~meta_r[`CALC_STAGES].poison;
  assign wb_rd_addr_o = meta_r[`CALC_STAGES].rd_addr;

  a_one_pipe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dispatch_pkt_i.v |-> !(dispatch_pkt_i.pipe_int_v && dispatch_pkt_i.pipe_mul_v));

  // Nothing that was in flight during a flush may reach the register file
  a_flush_no_wb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(flush_i) |-> !wb_w_v_o);

endmodule

//--- rtl/operand_stage.sv
/*
 * Operand stage
 * Bypasses in-flight results into the sources and holds the reservation register
 */
`include "calc_defs.svh"

module operand_stage
(
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  calc_pkg::dispatch_pkt_s              dispatch_pkt_i,
  input  calc_pkg::fwd_slot_s [`CALC_STAGES:1] fwd_i,
  output calc_pkg::calc_op_e                   op_o,
  output calc_pkg::dword_t                     src1_o,
  output calc_pkg::dword_t                     src2_o
);

  import calc_pkg::*;

  dword_t   bypass_rs1;
  dword_t   bypass_rs2;
  dword_t   src2_n;
  calc_op_e op_r;
  dword_t   src1_r;
  dword_t   src2_r;

  // Oldest slot first so the youngest match overrides it
  function automatic dword_t bypass_src(input reg_addr_t addr, input dword_t rf_val,
                                        input fwd_slot_s [`CALC_STAGES:1] fwd);
    dword_t val;
    val = rf_val;
    for (int k = `CALC_STAGES; k >= 1; k--)
    begin
      if (fwd[k].v && (fwd[k].rd_addr == addr))
      begin
        val = fwd[k].data;
      end
    end
    // x0 is hardwired
    if (addr == '0)
    begin
      val = '0;
    end
    return val;
  endfunction

  assign bypass_rs1 = bypass_src(dispatch_pkt_i.rs1_addr, dispatch_pkt_i.rs1, fwd_i);
  assign bypass_rs2 = bypass_src(dispatch_pkt_i.rs2_addr, dispatch_pkt_i.rs2, fwd_i);
  assign src2_n     = dispatch_pkt_i.use_imm ? dispatch_pkt_i.imm : bypass_rs2;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      op_r <= OP_ADD;
    end
    else
    begin
      op_r <= dispatch_pkt_i.op;
    end
  end

  always_ff @(posedge clk_i)
  begin
    src1_r <= bypass_rs1;
    src2_r <= src2_n;
  end

  assign op_o   = op_r;
  assign src1_o = src1_r;
  assign src2_o = src2_r;

endmodule

//--- rtl/int_alu.sv
/*
 * Integer ALU
 * Single-cycle add, subtract, logic, shift and set-less-than
 */
`include "calc_defs.svh"

module int_alu
(
  input  calc_pkg::calc_op_e op_i,
  input  calc_pkg::dword_t   src1_i,
  input  calc_pkg::dword_t   src2_i,
  output calc_pkg::dword_t   result_o
);

  import calc_pkg::*;

  localparam int SHAMT_W = $clog2(`CALC_DWORD_W);

  logic [SHAMT_W-1:0] shamt;
  logic               lt_signed;

  // Shifts use only the low bits of the second source
  assign shamt     = src2_i[SHAMT_W-1:0];
  assign lt_signed = $signed(src1_i) < $signed(src2_i);

  always_comb
  begin
    case (op_i)
      OP_ADD:
        result_o = src1_i + src2_i;
      OP_SUB:
        result_o = src1_i - src2_i;
      OP_AND:
        result_o = src1_i & src2_i;
      OP_OR:
        result_o = src1_i | src2_i;
      OP_XOR:
        result_o = src1_i ^ src2_i;
      OP_SLL:
        result_o = src1_i << shamt;
      OP_SRL:
        result_o = src1_i >> shamt;
      OP_SLT:
        result_o = dword_t'(lt_signed);
      // Handled by the multiply pipe
      OP_MUL, OP_MULH, OP_MULHU:
        result_o = '0;
      default:
        result_o = '0;
    endcase
  end

endmodule

//--- rtl/mul_pipe.sv
/*
 * Two-stage multiplier
 * Extended operands are registered here, completion stage 2 captures the half
 */
`include "calc_defs.svh"

module mul_pipe
(
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  calc_pkg::calc_op_e op_i,
  input  calc_pkg::dword_t   src1_i,
  input  calc_pkg::dword_t   src2_i,
  output calc_pkg::dword_t   result_o
);

  import calc_pkg::*;

  localparam int W = `CALC_DWORD_W;

  logic           sign_ext;
  logic [2*W-1:0] src1_ext;
  logic [2*W-1:0] src2_ext;
  logic [2*W-1:0] src1_r;
  logic [2*W-1:0] src2_r;
  logic [2*W-1:0] product;
  logic           hi_sel_r;

  // MULH is signed by signed, MULHU and MUL use zero extension
  assign sign_ext = (op_i == OP_MULH);
  assign src1_ext = sign_ext ? {{W{src1_i[W-1]}}, src1_i} : {{W{1'b0}}, src1_i};
  assign src2_ext = sign_ext ? {{W{src2_i[W-1]}}, src2_i} : {{W{1'b0}}, src2_i};

  always_ff @(posedge clk_i)
  begin
    src1_r <= src1_ext;
    src2_r <= src2_ext;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      hi_sel_r <= 1'b0;
    end
    else
    begin
      hi_sel_r <= (op_i == OP_MULH) || (op_i == OP_MULHU);
    end
  end

  // Product modulo 2^64 is exact for both extensions
  assign product  = src1_r * src2_r;
  assign result_o = hi_sel_r ? product[2*W-1:W] : product[W-1:0];

endmodule

//--- rtl/comp_pipe.sv
/*
 * Completion data pipe
 * Merges each pipe result into its stage and shifts it to the writeback point
 */
`include "calc_defs.svh"

module comp_pipe
(
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              int_done_i,
  input  logic                              mul_done_i,
  input  calc_pkg::dword_t                  int_result_i,
  input  calc_pkg::dword_t                  mul_result_i,
  output calc_pkg::dword_t [`CALC_STAGES:1] comp_next_o,
  output calc_pkg::dword_t                  wb_data_o
);

  import calc_pkg::*;

  dword_t [`CALC_STAGES:1] stage_r;
  dword_t [`CALC_STAGES:1] stage_n;

  always_comb
  begin
    stage_n[1] = int_done_i ? int_result_i : '0;
    // Multiply finishes one stage later than the integer pipe
    stage_n[2] = mul_done_i ? mul_result_i : stage_r[1];
    for (int k = 3; k <= `CALC_STAGES; k++)
    begin
      stage_n[k] = stage_r[k-1];
    end
  end

  always_ff @(posedge clk_i)
  begin
    stage_r <= stage_n;
  end

  // Next values double as forwarding data
  assign comp_next_o = stage_n;
  assign wb_data_o   = stage_r[`CALC_STAGES];

  // Each multiply is followed by an empty dispatch slot
  a_done_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(int_done_i && mul_done_i));

endmodule

//--- rtl/calc_top.sv
/*
 * Integer calculator top
 * Writeback appears in the cycle after the third edge following the dispatch edge
 */
`include "calc_defs.svh"

module calc_top
(
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  calc_pkg::dispatch_pkt_s dispatch_pkt_i,
  input  logic                    flush_i,
  output calc_pkg::wb_pkt_s       wb_pkt_o
);

  import calc_pkg::*;

  fwd_slot_s [`CALC_STAGES:1] fwd_ctrl;
  fwd_slot_s [`CALC_STAGES:1] fwd;
  dword_t [`CALC_STAGES:1] comp_next;

  calc_op_e  op;
  dword_t    src1;
  dword_t    src2;
  dword_t    int_result;
  dword_t    mul_result;
  dword_t    wb_data;
  logic      int_done;
  logic      mul_done;
  logic      wb_w_v;
  reg_addr_t wb_rd_addr;

  calc_ctrl u_calc_ctrl
  (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .dispatch_pkt_i (dispatch_pkt_i),
    .flush_i        (flush_i),
    .fwd_o          (fwd_ctrl),
    .int_done_o     (int_done),
    .mul_done_o     (mul_done),
    .wb_w_v_o       (wb_w_v),
    .wb_rd_addr_o   (wb_rd_addr)
  );

  // Slot addresses from control, slot data from the completion pipe
  always_comb
  begin
    fwd = fwd_ctrl;
    for (int k = 1; k <= `CALC_STAGES; k++)
    begin
      fwd[k].data = comp_next[k];
    end
  end

  operand_stage u_operand_stage
  (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .dispatch_pkt_i (dispatch_pkt_i),
    .fwd_i          (fwd),
    .op_o           (op),
    .src1_o         (src1),
    .src2_o         (src2)
  );

  int_alu u_int_alu
  (
    .op_i     (op),
    .src1_i   (src1),
    .src2_i   (src2),
    .result_o (int_result)
  );

  mul_pipe u_mul_pipe
  (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .op_i     (op),
    .src1_i   (src1),
    .src2_i   (src2),
    .result_o (mul_result)
  );

  comp_pipe u_comp_pipe
  (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .int_done_i   (int_done),
    .mul_done_i   (mul_done),
    .int_result_i (int_result),
    .mul_result_i (mul_result),
    .comp_next_o  (comp_next),
    .wb_data_o    (wb_data)
  );

  assign wb_pkt_o.rd_w_v  = wb_w_v;
  assign wb_pkt_o.rd_addr = wb_rd_addr;
  assign wb_pkt_o.rd_data = wb_data;

endmodule

//--- sim/calc_tb_tasks.svh
/*
 * Calculator testbench tasks
 * Cycle driver with writeback checking, reference operations and directed tests
 */
`ifndef CALC_TB_TASKS_SVH
`define CALC_TB_TASKS_SVH

task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
  if (got !== exp)
  begin
    $display("mismatch at time %0t: %s is %h, expected %h", $time, what, got, exp);
    $display("TEST FAIL");
    $fatal(1, "stopping at the first wrong value");
  end
endtask

// Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
function automatic dword_t rand_bits(input int n);
  dword_t val;
  val = '0;
  for (int i = 0; i < n; i++)
  begin
    if (lfsr[0])
    begin
      lfsr = (lfsr >> 1) ^ 32'h8020_0003;
    end
    else
    begin
      lfsr = lfsr >> 1;
    end
    val = {val[30:0], lfsr[0]};
  end
  return val;
endfunction

// Instruction semantics as RV32IM defines them
function automatic dword_t ref_result(input calc_op_e op, input dword_t a, input dword_t b);
  longint          sa;
  longint          sb;
  longint unsigned ua;
  longint unsigned ub;
  logic [63:0]     prod;
  dword_t          res;
  sa = $signed(a);
  sb = $signed(b);
  ua = a;
  ub = b;
  res = '0;
  case (op)
    OP_ADD:   res = a + b;
    OP_SUB:   res = a - b;
    OP_AND:   res = a & b;
    OP_OR:    res = a | b;
    OP_XOR:   res = a ^ b;
    OP_SLL:   res = a << b[4:0];
    OP_SRL:   res = a >> b[4:0];
    OP_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    OP_MUL:
    begin
      prod = ua * ub;
      res  = prod[31:0];
    end
    OP_MULH:
    begin
      prod = sa * sb;
      res  = prod[63:32];
    end
    OP_MULHU:
    begin
      prod = ua * ub;
      res  = prod[63:32];
    end
    default:  res = '0;
  endcase
  return res;
endfunction

function automatic dispatch_pkt_s make_pkt(input calc_op_e op, input int rd, input int rs1,
                                           input int rs2, input logic use_imm, input dword_t imm);
  dispatch_pkt_s pkt;
  pkt            = '0;
  pkt.v          = 1'b1;
  pkt.pipe_mul_v = (op == OP_MUL) || (op == OP_MULH) || (op == OP_MULHU);
  pkt.pipe_int_v = !pkt.pipe_mul_v;
  pkt.irf_w_v    = 1'b1;
  pkt.op         = op;
  pkt.rd_addr    = reg_addr_t'(rd);
  pkt.rs1_addr   = reg_addr_t'(rs1);
  pkt.rs2_addr   = reg_addr_t'(rs2);
  pkt.use_imm    = use_imm;
  pkt.imm        = imm;
  return pkt;
endfunction

// One cycle: check the writeback due now, update the issuer file, then dispatch
task automatic step(input dispatch_pkt_s pkt, input logic kill);
  wb_pkt_s got;
  wb_pkt_s exp;
  dword_t  src2;
  @(negedge clk);
  got = wb_pkt;
  // Front entry was dispatched four rising edges ago
  if (exp_q.size() == 4)
  begin
    exp = exp_q.pop_front();
    check_equal(got.rd_w_v, exp.rd_w_v, "writeback valid");
    if (exp.rd_w_v)
    begin
      check_equal(got.rd_addr, exp.rd_addr, "writeback address");
      check_equal(got.rd_data, exp.rd_data, "writeback data");
    end
  end
  if (got.rd_w_v && (got.rd_addr != 0))
  begin
    rf[got.rd_addr] = got.rd_data;
  end
  pkt.rs1      = rf[pkt.rs1_addr];
  pkt.rs2      = rf[pkt.rs2_addr];
  dispatch_pkt = pkt;
  flush        = kill;
  exp          = '0;
  if (kill)
  begin
    // Everything still queued is in flight and dies with the new packet
    for (int i = 0; i < exp_q.size(); i++)
    begin
      exp_q[i].rd_w_v = 1'b0;
    end
    arch_rf = rf;
  end
  else
  begin
    src2         = pkt.use_imm ? pkt.imm : arch_rf[pkt.rs2_addr];
    exp.rd_w_v   = pkt.v & pkt.irf_w_v;
    exp.rd_addr  = pkt.rd_addr;
    exp.rd_data  = ref_result(pkt.op, arch_rf[pkt.rs1_addr], src2);
    if (exp.rd_w_v && (pkt.rd_addr != 0))
    begin
      arch_rf[pkt.rd_addr] = exp.rd_data;
    end
  end
  exp_q.push_back(exp);
endtask

task automatic issue(input calc_op_e op, input int rd, input int rs1, input int rs2,
                     input logic use_imm, input dword_t imm);
  step(make_pkt(op, rd, rs1, rs2, use_imm, imm), 1'b0);
endtask

task automatic idle();
  step('0, 1'b0);
endtask

// Lets every queued writeback reach its check
task automatic drain();
  repeat (4) idle();
endtask

task automatic int_op_sweep();
  issue(OP_ADD, 1, 0, 0, 1'b1, 32'h8000_0F05);
  issue(OP_ADD, 2, 0, 0, 1'b1, 32'h0000_0023);
  issue(OP_ADD, 3, 0, 0, 1'b1, 32'hFFFF_FFF9);
  for (int i = 0; i < 8; i++)
  begin
    issue(calc_op_e'(4'(i)), 10 + i, 1, 2, 1'b0, '0);
    issue(calc_op_e'(4'(i)), 20 + i, 3, 1, 1'b1, 32'h0000_0007 + i);
  end
  drain();
endtask

task automatic mul_op_sweep();
  issue(OP_ADD, 4, 0, 0, 1'b1, 32'h8000_0000);
  issue(OP_ADD, 5, 0, 0, 1'b1, 32'hFFFF_FFFF);
  issue(OP_ADD, 6, 0, 0, 1'b1, 32'h7FFF_FFFF);
  for (int i = 8; i <= 10; i++)
  begin
    issue(calc_op_e'(4'(i)), 26, 4, 5, 1'b0, '0);
    idle();
    issue(calc_op_e'(4'(i)), 27, 5, 6, 1'b0, '0);
    idle();
    issue(calc_op_e'(4'(i)), 28, 4, 4, 1'b0, '0);
    idle();
    issue(calc_op_e'(4'(i)), 29, 6, 5, 1'b0, '0);
    idle();
  end
  drain();
endtask

task automatic forward_chains();
  issue(OP_ADD, 7, 0, 0, 1'b1, 32'd3);
  issue(OP_ADD, 7, 7, 7, 1'b0, '0);
  issue(OP_SLL, 8, 7, 0, 1'b1, 32'd4);
  issue(OP_SUB, 9, 8, 7, 1'b0, '0);
  // x7 now sits three slots back
  issue(OP_XOR, 10, 7, 9, 1'b0, '0);
  issue(OP_MUL, 11, 9, 10, 1'b0, '0);
  idle();
  issue(OP_ADD, 12, 11, 0, 1'b0, '0);
  issue(OP_MULHU, 13, 11, 8, 1'b0, '0);
  idle();
  issue(OP_OR, 14, 13, 11, 1'b0, '0);
  drain();
endtask

task automatic reg_zero_rules();
  issue(OP_ADD, 0, 0, 0, 1'b1, 32'h0000_1234);
  issue(OP_ADD, 20, 0, 0, 1'b0, '0);
  issue(OP_OR, 21, 0, 0, 1'b1, 32'd5);
  issue(OP_MUL, 0, 21, 21, 1'b0, '0);
  idle();
  issue(OP_ADD, 22, 0, 21, 1'b0, '0);
  drain();
  check_equal(rf[20], 0, "x20 read of x0");
  check_equal(rf[22], 5, "x22 read of x0 after multiply");
endtask

task automatic flush_kill();
  issue(OP_ADD, 15, 0, 0, 1'b1, 32'd100);
  drain();
  issue(OP_ADD, 15, 15, 0, 1'b1, 32'd1);
  issue(OP_MUL, 16, 15, 15, 1'b0, '0);
  idle();
  step(make_pkt(OP_ADD, 17, 15, 0, 1'b1, 32'd7), 1'b1);
  issue(OP_ADD, 18, 15, 0, 1'b1, '0);
  drain();
  check_equal(rf[15], 100, "x15 after flush");
  issue(OP_SUB, 19, 15, 18, 1'b0, '0);
  issue(OP_ADD, 15, 19, 0, 1'b1, 32'd9);
  drain();
  check_equal(rf[15], 9, "x15 written after flush");
endtask

task automatic random_sequence();
  calc_op_e op;
  dword_t   rd;
  dword_t   rs1;
  dword_t   rs2;
  dword_t   use_imm;
  dword_t   imm;
  for (int n = 0; n < 200; n++)
  begin
    op      = calc_op_e'(4'(rand_bits(4) % 11));
    rd      = rand_bits(3);
    rs1     = rand_bits(3);
    rs2     = rand_bits(3);
    use_imm = rand_bits(1);
    imm     = rand_bits(32);
    issue(op, rd, rs1, rs2, use_imm[0], imm);
    // Product is not forwardable in the next cycle
    if ((op == OP_MUL) || (op == OP_MULH) || (op == OP_MULHU))
    begin
      idle();
    end
  end
  drain();
endtask

`endif

//--- sim/calc_tb.sv
/*
 * Calculator testbench
 * Clock, reset, DUT, timeout, issuer register file and the directed test sequence
 */

module calc_tb;

  import calc_pkg::*;

  // Reset plus every test, with each random multiply followed by its gap
  localparam int TEST_CYCLES = 560;
  localparam int MAX_CYCLES  = 2 * TEST_CYCLES + 100;

  logic          clk;
  logic          rst_n;
  dispatch_pkt_s dispatch_pkt;
  logic          flush;
  wb_pkt_s       wb_pkt;

  // Issuer copy fed by writeback, and the in-order architectural model
  dword_t        rf [32];
  dword_t        arch_rf [32];
  wb_pkt_s       exp_q [$];
  logic [31:0]   lfsr;
  int            cycle_cnt;

  calc_top u_calc_top
  (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .dispatch_pkt_i (dispatch_pkt),
    .flush_i        (flush),
    .wb_pkt_o       (wb_pkt)
  );

  always #10 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES)
    begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAIL");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  `include "calc_tb_tasks.svh"

  initial
  begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    dispatch_pkt = '0;
    flush        = 1'b0;
    cycle_cnt    = 0;
    lfsr         = 32'd51;
    for (int i = 0; i < 32; i++)
    begin
      rf[i]      = '0;
      arch_rf[i] = '0;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_equal(wb_pkt.rd_w_v, 0, "writeback valid after reset");

    int_op_sweep();
    mul_op_sweep();
    forward_chains();
    reg_zero_rules();
    flush_kill();
    random_sequence();

    $display("TEST PASS");
    $finish;
  end

endmodule

//--- sources.f
+incdir+rtl
+incdir+sim
rtl/calc_pkg.sv
rtl/calc_ctrl.sv
rtl/operand_stage.sv
rtl/int_alu.sv
rtl/mul_pipe.sv
rtl/comp_pipe.sv
rtl/calc_top.sv
sim/calc_tb.sv
